/* rtl/lsu_bus_if.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

interface lsu_bus_if;

   logic [`LSU_XLEN-1:0] adr;
   logic [`LSU_XLEN-1:0] dat; // Write data.
   logic [3:0]           sel;
   logic                 we;
   logic                 cyc;
   logic                 stb;
   logic [`LSU_XLEN-1:0] rdt; // Read data.
   logic                 ack;

   modport master (
      output adr, dat, sel, we, cyc, stb,
      input  rdt, ack
   );

   modport slave (
      input  adr, dat, sel, we, cyc, stb,
      output rdt, ack
   );

endinterface

/* rtl/lsu_mem_if.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_mem_if
   import lsu_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic        i_en,
   input  logic        i_init,
   input  logic        i_dat_valid,
   input  logic        i_cmd,
   input  lsu_funct3_e i_funct3,
   input  logic        i_rs1,
   input  logic        i_rs2,
   input  logic        i_imm,
   input  logic        i_trap,
   output logic        o_rd,
   output logic        o_busy,
   output logic        o_misalign,
   lsu_bus_if.master   bus
);

   logic                 adr_bit;
   logic [`LSU_XLEN-1:0] adr;
   logic                 init_r;
   logic [4:0]           cnt;
   logic [1:0]           bytepos;
   logic [1:0]           mis;
   logic [`LSU_XLEN-1:0] dat;
   logic                 signbit;
   logic                 dat_en;
   logic                 cyc_r;
   logic                 wb_en;
   logic                 is_word;
   logic                 is_half;
   logic                 is_byte;
   logic                 is_signed;
   lsu_word_u            st_w;
   lsu_word_u            ld_w;

   assign is_word   = i_funct3[1];
   assign is_half   = i_funct3[0];
   assign is_byte   = ~(|i_funct3[1:0]);
   assign is_signed = ~i_funct3[2];

   assign wb_en = cyc_r & bus.ack;

   // rs1 + imm, one bit per init cycle.
   ser_add u_adr_add (
      .i_clk (i_clk),
      .i_a   (i_rs1),
      .i_b   (i_imm),
      .i_clr (~i_init),
      .o_q   (adr_bit)
   );

   // The sum lags by one cycle, so the address shifts on the delayed init.
   shift_reg #(.LEN(`LSU_XLEN)) u_adr_sr (
      .i_clk   (i_clk),
      .i_load  (1'b0),
      .i_par_d ('0),
      .i_en    (init_r),
      .i_d     (adr_bit),
      .o_q     (),
      .o_par   (adr)
   );

   // Store data needs only as many rs2 bits as the access width.
   always_comb begin
      if (is_word) begin
         dat_en = 1'b1;
      end else if (is_half) begin
         dat_en = ~cnt[4];
      end else begin
         dat_en = (cnt[4:3] == 2'b00);
      end
   end

   // Replicate the value into every lane; sel picks the live one.
   always_comb begin
      if (is_word) begin
         st_w.w = dat;
      end else if (is_half) begin
         st_w.h = {2{dat[`LSU_XLEN-1 -: 16]}};
      end else begin
         st_w.b = {4{dat[`LSU_XLEN-1 -: 8]}};
      end
   end

   assign ld_w = bus.rdt;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         init_r <= 1'b0;
         cnt    <= 5'd0;
         mis    <= 2'b00;
         o_busy <= 1'b0;
         cyc_r  <= 1'b0;
      end else begin
         init_r <= i_init;
         cnt    <= i_init ? cnt + 5'd1 : 5'd0;
         if (i_init && cnt == 5'd1) mis[0] <= ~is_byte & adr_bit; // Odd address.
         if (i_init && cnt == 5'd2) mis[1] <= is_word & adr_bit;
         if (i_trap) mis <= 2'b00;
         if (i_en & i_init) begin
            o_busy <= 1'b1;
         end else if (wb_en | i_trap) begin
            o_busy <= 1'b0;
         end
         if (wb_en) begin
            cyc_r <= 1'b0;
         end else if (init_r & ~i_init & ~o_misalign) begin
            cyc_r <= 1'b1; // Address is complete from here on.
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_init && cnt == 5'd1) bytepos[0] <= adr_bit;
      if (i_init && cnt == 5'd2) bytepos[1] <= adr_bit;
      if (i_dat_valid) signbit <= dat[0];
      if (wb_en & ~i_cmd) begin
         if (is_word) begin
            dat <= ld_w.w;
         end else if (is_half) begin
            dat <= {16'd0, ld_w.h[bytepos[1]]};
         end else begin
            dat <= {24'd0, ld_w.b[bytepos]};
         end
      end else if ((i_en & i_init & dat_en) | i_dat_valid) begin
         dat <= {i_rs2, dat[`LSU_XLEN-1:1]};
      end
   end

   assign o_rd       = i_dat_valid ? dat[0] : signbit & is_signed;
   assign o_misalign = |mis;

   assign bus.adr = adr;
   assign bus.dat = st_w;
   assign bus.sel = is_word ? 4'b1111 :
                    is_half ? (bytepos[1] ? 4'b1100 : 4'b0011) :
                    4'b0001 << bytepos;
   assign bus.we  = i_cmd;
   assign bus.cyc = cyc_r;
   assign bus.stb = cyc_r;

endmodule

/* rtl/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

   // Access kinds. Stores use the same codes with bit 2 ignored.
   typedef enum logic [2:0] {
      F3_LB  = 3'b000,
      F3_LH  = 3'b001,
      F3_LW  = 3'b010,
      F3_LBU = 3'b100,
      F3_LHU = 3'b101
   } lsu_funct3_e;

   // One bus word, seen whole, as halves or as byte lanes.
   typedef union packed {
      logic [`LSU_XLEN-1:0] w;
      logic [1:0][15:0]     h;
      logic [3:0][7:0]      b;
   } lsu_word_u;

endpackage

/* rtl/lsu_ram.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_ram
   import lsu_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rst_n,
   lsu_bus_if.slave bus
);

   lsu_word_u              mem [`LSU_RAM_WORDS];
   lsu_word_u              wr_w;
   logic [`LSU_RAM_AW-1:0] idx;
   logic [`LSU_XLEN-1:0]   rdt_r;
   logic                   ack_r;
   logic                   req;

   assign wr_w = bus.dat;
   assign idx  = bus.adr[`LSU_RAM_AW+1:2];
   assign req  = bus.cyc & bus.stb & ~ack_r; // One access per cycle.

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ack_r <= 1'b0;
      end else begin
         ack_r <= req;
      end
   end

   always_ff @(posedge i_clk) begin
      if (req & bus.we) begin
         for (int i = 0; i < 4; i++) begin
            if (bus.sel[i]) mem[idx].b[i] <= wr_w.b[i];
         end
      end
      if (req) rdt_r <= mem[idx];
   end

   assign bus.rdt = rdt_r;
   assign bus.ack = ack_r;

endmodule

/* rtl/lsu_sequencer.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_sequencer
   import lsu_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_cmd_valid,
   output logic                 o_cmd_ready,
   input  logic                 i_cmd_we,
   input  lsu_funct3_e          i_cmd_funct3,
   input  logic [`LSU_XLEN-1:0] i_cmd_rs1,
   input  logic [`LSU_XLEN-1:0] i_cmd_rs2,
   input  logic [`LSU_XLEN-1:0] i_cmd_imm,
   output logic                 o_rsp_valid,
   input  logic                 i_rsp_ready,
   output logic [`LSU_XLEN-1:0] o_rsp_rdata,
   output logic                 o_rsp_misalign,
   output logic                 o_en,
   output logic                 o_init,
   output logic                 o_dat_valid,
   output logic                 o_trap,
   output logic                 o_cmd,
   output lsu_funct3_e          o_funct3,
   output logic                 o_rs1,
   output logic                 o_rs2,
   output logic                 o_imm,
   input  logic                 i_rd,
   input  logic                 i_busy,
   input  logic                 i_misalign
);

   localparam logic [2:0] S_IDLE = 3'd0;
   localparam logic [2:0] S_INIT = 3'd1;
   localparam logic [2:0] S_WAIT = 3'd2;
   localparam logic [2:0] S_TRAP = 3'd3;
   localparam logic [2:0] S_DATA = 3'd4;
   localparam logic [2:0] S_RESP = 3'd5;

   logic [2:0]  state;
   logic [4:0]  cnt;
   logic        cmd_we;
   lsu_funct3_e funct3;
   logic        mis_flag;
   logic        accept;
   logic        data_en;

   assign o_cmd_ready = (state == S_IDLE);
   assign accept      = i_cmd_valid & o_cmd_ready;
   assign data_en     = (state == S_DATA);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state    <= S_IDLE;
         cnt      <= 5'd0;
         cmd_we   <= 1'b0;
         funct3   <= F3_LB;
         mis_flag <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (accept) begin
               cmd_we   <= i_cmd_we;
               funct3   <= i_cmd_funct3;
               mis_flag <= 1'b0;
               cnt      <= 5'd0;
               state    <= S_INIT;
            end
            S_INIT: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31) state <= S_WAIT;
            end
            S_WAIT: if (i_misalign) begin
               state <= S_TRAP;
            end else if (!i_busy) begin
               cnt   <= 5'd0;
               state <= cmd_we ? S_RESP : S_DATA; // Stores have no data phase.
            end
            S_TRAP: begin
               mis_flag <= 1'b1;
               state    <= S_RESP;
            end
            S_DATA: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31) state <= S_RESP;
            end
            S_RESP: if (i_rsp_ready) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   shift_reg #(.LEN(`LSU_XLEN)) u_rs1_sr (
      .i_clk (i_clk), .i_load (accept), .i_par_d (i_cmd_rs1),
      .i_en (o_init), .i_d (1'b0), .o_q (o_rs1), .o_par ()
   );

   shift_reg #(.LEN(`LSU_XLEN)) u_rs2_sr (
      .i_clk (i_clk), .i_load (accept), .i_par_d (i_cmd_rs2),
      .i_en (o_init), .i_d (1'b0), .o_q (o_rs2), .o_par ()
   );

   shift_reg #(.LEN(`LSU_XLEN)) u_imm_sr (
      .i_clk (i_clk), .i_load (accept), .i_par_d (i_cmd_imm),
      .i_en (o_init), .i_d (1'b0), .o_q (o_imm), .o_par ()
   );

   // Cleared on accept, so stores and traps answer zero.
   shift_reg #(.LEN(`LSU_XLEN)) u_res_sr (
      .i_clk (i_clk), .i_load (accept), .i_par_d ('0),
      .i_en (data_en), .i_d (i_rd), .o_q (), .o_par (o_rsp_rdata)
   );

   assign o_init         = (state == S_INIT);
   assign o_en           = o_init | data_en;
   assign o_trap         = (state == S_TRAP);
   assign o_rsp_valid    = (state == S_RESP);
   assign o_rsp_misalign = mis_flag;
   assign o_cmd          = cmd_we;
   assign o_funct3       = funct3;
   assign o_dat_valid    = data_en & (funct3[1] | (funct3[0] & ~cnt[4]) |
                                      (cnt[4:3] == 2'b00)); // Width-limited bits.

endmodule

/* rtl/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data and address width.
`define LSU_XLEN 32

// RAM depth in words.
`define LSU_RAM_WORDS 64

// Word address bits, log2 of the depth.
`define LSU_RAM_AW 6

`endif

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top
   import lsu_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_cmd_valid,
   output logic                 o_cmd_ready,
   input  logic                 i_cmd_we,
   input  lsu_funct3_e          i_cmd_funct3,
   input  logic [`LSU_XLEN-1:0] i_cmd_rs1,
   input  logic [`LSU_XLEN-1:0] i_cmd_rs2,
   input  logic [`LSU_XLEN-1:0] i_cmd_imm,
   output logic                 o_rsp_valid,
   input  logic                 i_rsp_ready,
   output logic [`LSU_XLEN-1:0] o_rsp_rdata,
   output logic                 o_rsp_misalign
);

   logic        en;
   logic        init;
   logic        dat_valid;
   logic        trap;
   logic        cmd;
   lsu_funct3_e funct3;
   logic        rs1;
   logic        rs2;
   logic        imm;
   logic        rd;
   logic        busy;
   logic        misalign;

   lsu_bus_if bus_i ();

   lsu_sequencer u_seq (
      .i_clk, .i_rst_n,
      .i_cmd_valid, .o_cmd_ready, .i_cmd_we, .i_cmd_funct3,
      .i_cmd_rs1, .i_cmd_rs2, .i_cmd_imm,
      .o_rsp_valid, .i_rsp_ready, .o_rsp_rdata, .o_rsp_misalign,
      .o_en (en), .o_init (init), .o_dat_valid (dat_valid), .o_trap (trap),
      .o_cmd (cmd), .o_funct3 (funct3),
      .o_rs1 (rs1), .o_rs2 (rs2), .o_imm (imm),
      .i_rd (rd), .i_busy (busy), .i_misalign (misalign)
   );

   lsu_mem_if u_mem_if (
      .i_clk, .i_rst_n,
      .i_en (en), .i_init (init), .i_dat_valid (dat_valid), .i_cmd (cmd),
      .i_funct3 (funct3), .i_rs1 (rs1), .i_rs2 (rs2), .i_imm (imm),
      .i_trap (trap),
      .o_rd (rd), .o_busy (busy), .o_misalign (misalign),
      .bus (bus_i.master)
   );

   lsu_ram u_ram (
      .i_clk, .i_rst_n,
      .bus (bus_i.slave)
   );

endmodule

/* rtl/ser_add.sv */
`timescale 1ns/1ps

module ser_add (
   input  logic i_clk,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic c_r;
   logic sum;
   logic cout;

   assign sum  = i_a ^ i_b ^ c_r;
   assign cout = (i_a & i_b) | (c_r & (i_a ^ i_b));

   always_ff @(posedge i_clk) begin
      c_r <= cout & ~i_clr; // Carry held only while adding.
      o_q <= sum;
   end

endmodule

/* rtl/shift_reg.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module shift_reg #(
   parameter int LEN = `LSU_XLEN
) (
   input  logic           i_clk,
   input  logic           i_load,
   input  logic [LEN-1:0] i_par_d,
   input  logic           i_en,
   input  logic           i_d,
   output logic           o_q,
   output logic [LEN-1:0] o_par
);

   logic [LEN-1:0] sr;

   always_ff @(posedge i_clk) begin
      if (i_load) begin
         sr <= i_par_d;
      end else if (i_en) begin
         sr <= {i_d, sr[LEN-1:1]}; // New bit enters at the top.
      end
   end

   assign o_q   = sr[0];
   assign o_par = sr;

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile the LSU testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   --timescale 1ns/1ps \
   --top-module tb_lsu \
   -f tb.f \
   -o Vtb_lsu

# A $fatal in the testbench gives a nonzero exit status.
./obj_dir/Vtb_lsu

/* tb.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_bus_if.sv
rtl/ser_add.sv
rtl/shift_reg.sv
rtl/lsu_mem_if.sv
rtl/lsu_sequencer.sv
rtl/lsu_ram.sv
rtl/lsu_top.sv
tb/tb_lsu.sv

/* tb/tb_lsu.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_lsu
   import lsu_pkg::*;
();

   localparam int RESET_CYCLES = 10;
   localparam int N_CMDS       = 60; // Commands issued over all tests.
   localparam int CYCLE_LIMIT  = N_CMDS * 120 + RESET_CYCLES;
   localparam int MEM_BYTES    = `LSU_RAM_WORDS * 4;

   logic                 clk;
   logic                 rst_n;
   logic                 cmd_valid;
   logic                 cmd_ready;
   logic                 cmd_we;
   lsu_funct3_e          cmd_funct3;
   logic [`LSU_XLEN-1:0] cmd_rs1;
   logic [`LSU_XLEN-1:0] cmd_rs2;
   logic [`LSU_XLEN-1:0] cmd_imm;
   logic                 rsp_valid;
   logic                 rsp_ready;
   logic [`LSU_XLEN-1:0] rsp_rdata;
   logic                 rsp_misalign;
   int                   cycles = 0;

   logic [7:0]           model_mem [int unsigned]; // Byte-addressed reference memory.

   // Commands of the back-pressure test and their predicted responses.
   logic                 q_we  [$];
   lsu_funct3_e          q_f3  [$];
   logic [`LSU_XLEN-1:0] q_rs1 [$];
   logic [`LSU_XLEN-1:0] q_rs2 [$];
   logic [`LSU_XLEN-1:0] q_imm [$];
   lsu_word_u            q_exp [$];
   logic                 q_mis [$];

   lsu_top dut_i (
      .i_clk          (clk),
      .i_rst_n        (rst_n),
      .i_cmd_valid    (cmd_valid),
      .o_cmd_ready    (cmd_ready),
      .i_cmd_we       (cmd_we),
      .i_cmd_funct3   (cmd_funct3),
      .i_cmd_rs1      (cmd_rs1),
      .i_cmd_rs2      (cmd_rs2),
      .i_cmd_imm      (cmd_imm),
      .o_rsp_valid    (rsp_valid),
      .i_rsp_ready    (rsp_ready),
      .o_rsp_rdata    (rsp_rdata),
      .o_rsp_misalign (rsp_misalign)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("Test failed");
         $fatal(1, "Timeout: the tests did not finish within %0d cycles.", CYCLE_LIMIT);
      end
   end

   task automatic step();
      @(posedge clk);
      #1; // Inputs change and outputs are read just after the edge.
   endtask

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "Stopped at the first mismatch.");
   endtask

   task automatic check_word(input string name, input lsu_word_u exp, input lsu_word_u act);
      if (act.w !== exp.w) begin
         $display("** Error %s: expected %h, actual %h", name, exp.w, act.w);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   // Applies one access to the reference memory and predicts the response.
   task automatic model_apply(input logic we, input lsu_funct3_e f3,
         input logic [31:0] addr, input logic [31:0] data,
         output lsu_word_u exp, output logic exp_mis);
      int unsigned idx;
      logic [15:0] h;
      idx     = addr & (MEM_BYTES - 1);
      exp.w   = '0;
      exp_mis = (f3[1:0] == 2'b01 && addr[0]) || (f3[1:0] == 2'b10 && addr[1:0] != 2'b00);
      if (!exp_mis && we) begin
         model_mem[idx] = data[7:0];
         if (f3[1:0] != 2'b00) begin
            model_mem[idx + 1] = data[15:8];
         end
         if (f3[1:0] == 2'b10) begin
            model_mem[idx + 2] = data[23:16];
            model_mem[idx + 3] = data[31:24];
         end
      end else if (!exp_mis) begin
         h = {model_mem[idx + 1], model_mem[idx]};
         case (f3)
            F3_LB:   exp.w = {{24{model_mem[idx][7]}}, model_mem[idx]};
            F3_LBU:  exp.w = {24'd0, model_mem[idx]};
            F3_LH:   exp.w = {{16{h[15]}}, h};
            F3_LHU:  exp.w = {16'd0, h};
            default: exp.w = {model_mem[idx + 3], model_mem[idx + 2], h};
         endcase
      end
   endtask

   task automatic send_cmd(input logic we, input lsu_funct3_e f3, input logic [31:0] rs1,
         input logic [31:0] rs2, input logic [31:0] imm);
      cmd_we     = we;
      cmd_funct3 = f3;
      cmd_rs1    = rs1;
      cmd_rs2    = rs2;
      cmd_imm    = imm;
      cmd_valid  = 1'b1;
      while (!cmd_ready) step();
      step(); // Transfer happens on this edge.
      cmd_valid = 1'b0;
   endtask

   task automatic wait_rsp(output lsu_word_u data, output logic mis);
      while (!rsp_valid) step();
      data      = rsp_rdata;
      mis       = rsp_misalign;
      rsp_ready = 1'b1;
      step();
      rsp_ready = 1'b0;
   endtask

   // Address is split into a random rs1 and a matching imm.
   task automatic run_cmd(input string name, input logic we, input lsu_funct3_e f3,
         input logic [31:0] addr, input logic [31:0] data);
      lsu_word_u   exp;
      lsu_word_u   got;
      logic        exp_mis;
      logic        got_mis;
      logic [31:0] base;
      base = $urandom();
      model_apply(we, f3, addr, data, exp, exp_mis);
      send_cmd(we, f3, base, data, addr - base);
      wait_rsp(got, got_mis);
      check_flag({name, " misalign"}, exp_mis, got_mis);
      check_word(name, exp, got);
   endtask

   task automatic test_word_rw();
      logic [31:0] addr;
      for (int i = 0; i < 8; i++) begin
         addr      = $urandom();
         addr[1:0] = 2'b00;
         run_cmd("word_rw SW", 1'b1, F3_LW, addr, $urandom());
         run_cmd("word_rw LW", 1'b0, F3_LW, addr, $urandom());
      end
   endtask

   task automatic test_byte_lanes();
      logic [31:0] tmp;
      logic [31:0] base;
      logic [31:0] data;
      tmp  = $urandom();
      base = {tmp[31:8], 8'h40};
      for (int k = 0; k < 4; k++) begin
         data    = $urandom();
         data[7] = k[0]; // Mix of negative and positive bytes.
         run_cmd($sformatf("byte_lanes SB +%0d", k), 1'b1, F3_LB, base + k, data);
      end
      run_cmd("byte_lanes LW", 1'b0, F3_LW, base, $urandom());
      for (int k = 0; k < 4; k++) begin
         run_cmd($sformatf("byte_lanes LB +%0d", k), 1'b0, F3_LB, base + k, $urandom());
         run_cmd($sformatf("byte_lanes LBU +%0d", k), 1'b0, F3_LBU, base + k, $urandom());
      end
   endtask

   task automatic test_half_lanes();
      logic [31:0] tmp;
      logic [31:0] base;
      logic [31:0] data;
      tmp  = $urandom();
      base = {tmp[31:8], 8'h80};
      data     = $urandom();
      data[15] = 1'b1;
      run_cmd("half_lanes SH +0", 1'b1, F3_LH, base, data);
      data     = $urandom();
      data[15] = 1'b0;
      run_cmd("half_lanes SH +2", 1'b1, F3_LH, base + 2, data);
      run_cmd("half_lanes LW", 1'b0, F3_LW, base, $urandom());
      for (int k = 0; k < 4; k += 2) begin
         run_cmd($sformatf("half_lanes LH +%0d", k), 1'b0, F3_LH, base + k, $urandom());
         run_cmd($sformatf("half_lanes LHU +%0d", k), 1'b0, F3_LHU, base + k, $urandom());
      end
   endtask

   task automatic test_misalign();
      logic [31:0] tmp;
      logic [31:0] base;
      tmp  = $urandom();
      base = {tmp[31:8], 8'hc0};
      run_cmd("misalign SW", 1'b1, F3_LW, base, $urandom());
      run_cmd("misalign LH +1", 1'b0, F3_LH, base + 1, $urandom());
      run_cmd("misalign LH +3", 1'b0, F3_LH, base + 3, $urandom());
      for (int k = 1; k < 4; k++) begin
         run_cmd($sformatf("misalign LW +%0d", k), 1'b0, F3_LW, base + k, $urandom());
      end
      run_cmd("misalign SH +1", 1'b1, F3_LH, base + 1, $urandom());
      run_cmd("misalign LW after traps", 1'b0, F3_LW, base, $urandom());
   endtask

   task automatic queue_cmd(input logic we, input lsu_funct3_e f3,
         input logic [31:0] addr, input logic [31:0] data);
      lsu_word_u   exp;
      logic        mis;
      logic [31:0] base;
      base = $urandom();
      model_apply(we, f3, addr, data, exp, mis);
      q_we.push_back(we);
      q_f3.push_back(f3);
      q_rs1.push_back(base);
      q_rs2.push_back(data);
      q_imm.push_back(addr - base);
      q_exp.push_back(exp);
      q_mis.push_back(mis);
   endtask

   task automatic drive_queued(input int i);
      cmd_we     = q_we[i];
      cmd_funct3 = q_f3[i];
      cmd_rs1    = q_rs1[i];
      cmd_rs2    = q_rs2[i];
      cmd_imm    = q_imm[i];
      cmd_valid  = 1'b1;
   endtask

   // The next command waits on the inputs while each response is held off.
   task automatic test_backpressure();
      logic [31:0] word;
      int unsigned pos;
      int unsigned stall;
      for (int r = 0; r < 4; r++) begin
         word      = $urandom();
         word[1:0] = 2'b00;
         pos       = $urandom_range(0, 3);
         queue_cmd(1'b1, F3_LW, word, $urandom());
         queue_cmd(1'b1, F3_LB, word + pos, $urandom());
         queue_cmd(1'b0, F3_LW, word, $urandom());
         pos = 2 * $urandom_range(0, 1);
         queue_cmd(1'b0, r[0] ? F3_LHU : F3_LH, word + pos, $urandom());
      end
      for (int i = 0; i < q_we.size(); i++) begin
         drive_queued(i);
         while (!cmd_ready) step();
         step();
         if (i + 1 < q_we.size()) begin
            drive_queued(i + 1);
         end else begin
            cmd_valid = 1'b0;
         end
         while (!rsp_valid) begin
            check_flag("backpressure busy cmd_ready", 1'b0, cmd_ready);
            step();
         end
         stall = $urandom_range(0, 6);
         repeat (stall) begin
            check_flag("backpressure stall cmd_ready", 1'b0, cmd_ready);
            check_flag("backpressure stall rsp_valid", 1'b1, rsp_valid);
            check_word($sformatf("backpressure stall data %0d", i), q_exp[i], rsp_rdata);
            step();
         end
         check_flag($sformatf("backpressure misalign %0d", i), q_mis[i], rsp_misalign);
         check_word($sformatf("backpressure data %0d", i), q_exp[i], rsp_rdata);
         rsp_ready = 1'b1;
         step();
         rsp_ready = 1'b0;
      end
   endtask

   initial begin
      void'($urandom(32'h10c9_711d));
      clk        = 1'b0;
      rst_n      = 1'b0;
      cmd_valid  = 1'b0;
      cmd_we     = 1'b0;
      cmd_funct3 = F3_LB;
      cmd_rs1    = '0;
      cmd_rs2    = '0;
      cmd_imm    = '0;
      rsp_ready  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_flag("reset cmd_ready", 1'b1, cmd_ready);
      check_flag("reset rsp_valid", 1'b0, rsp_valid);
      test_word_rw();
      test_byte_lanes();
      test_half_lanes();
      test_misalign();
      test_backpressure();
      $display("Test completed successfully");
      $finish;
   end

endmodule
